/* logic/cache_geom_pkg.sv */
package cache_geom_pkg;

  // --------------------
  // Geometry
  // --------------------
  localparam int num_ways  = 4;
  localparam int num_sets  = 8;
  localparam int way_bits  = 2;
  localparam int set_bits  = 3;
  localparam int tag_bits  = 13;
  localparam int addr_bits = 16;                  // Word address.
  localparam int data_bits = 32;                  // One word per line.

  typedef logic [addr_bits-1:0] addr_t;
  typedef logic [tag_bits-1:0]  tag_t;
  typedef logic [set_bits-1:0]  set_t;
  typedef logic [way_bits-1:0]  way_t;            // Way index or LRU age, 0 is newest.
  typedef logic [data_bits-1:0] data_t;

  // --------------------
  // Data array write source
  // --------------------
  typedef logic [1:0] data_sel_t;

  localparam data_sel_t data_sel_mem  = 2'b00;    // Line fill.
  localparam data_sel_t data_sel_cpu  = 2'b01;    // Store hit.
  localparam data_sel_t data_sel_none = 2'b11;

  typedef enum logic {
    check_hit,
    read_mem
  } ctrl_state_e;

endpackage : cache_geom_pkg

/* logic/pmem_pkg.sv */
package pmem_pkg;

  // --------------------
  // Shared memory port
  // --------------------
  localparam int num_requesters = 2;

  // Index of a cache on the shared port.
  typedef logic [$clog2(num_requesters)-1:0] req_id_t;

  localparam req_id_t req_icache = 1'b0;
  localparam req_id_t req_dcache = 1'b1;

endpackage : pmem_pkg

/* logic/cache_control.sv */
`timescale 1ns/1ps

module cache_control (
  input  logic                        clk,
  input  logic                        rst_n,

  // CPU side.
  input  logic                        mem_read,
  input  logic                        mem_write,
  output logic                        mem_resp,

  // Memory side.
  input  logic                        pmem_resp,
  output logic                        pmem_read,
  output logic                        pmem_write,

  // Datapath control.
  output logic                        tag_load,
  output logic                        valid_load,
  output logic                        dirty_load,
  output logic                        dirty_in,
  input  logic                        dirty_out,
  input  logic                        hit,
  output cache_geom_pkg::data_sel_t   data_sel,

  // Replacement state, indexed by way.
  input  cache_geom_pkg::way_t        lru_out [cache_geom_pkg::num_ways],
  input  cache_geom_pkg::way_t        way_idx,
  input  logic                        valid_out [cache_geom_pkg::num_ways],
  output logic                        lru_load [cache_geom_pkg::num_ways],
  output cache_geom_pkg::way_t        lru_in [cache_geom_pkg::num_ways]
);

  import cache_geom_pkg::*;

  ctrl_state_e state;
  ctrl_state_e next_state;
  logic        req;                                // Any CPU access pending.

  assign req = mem_read | mem_write;

  // --------------------
  // Outputs per state
  // --------------------
  always_comb begin : state_actions
    tag_load   = 1'b0;
    valid_load = 1'b0;
    dirty_load = 1'b0;
    dirty_in   = 1'b0;
    data_sel   = data_sel_none;
    mem_resp   = 1'b0;
    pmem_read  = 1'b0;
    pmem_write = 1'b0;

    for (int w = 0; w < num_ways; w++) begin
      lru_load[w] = 1'b0;
      lru_in[w]   = '0;
    end

    case (state)
      check_hit: begin
        if (req && hit) begin
          mem_resp = 1'b1;
          if (mem_write) begin
            dirty_load = 1'b1;                     // Store marks the line dirty.
            dirty_in   = 1'b1;
            data_sel   = data_sel_cpu;
          end
          // Age the valid ways that were newer than the one touched.
          for (int w = 0; w < num_ways; w++) begin
            if (valid_out[w] && (lru_out[w] < lru_out[way_idx])) begin
              lru_load[w] = 1'b1;
              lru_in[w]   = lru_out[w] + 2'd1;
            end
          end
          lru_load[way_idx] = 1'b1;                // Touched way becomes newest.
          lru_in[way_idx]   = '0;
        end else if (req && dirty_out) begin
          pmem_write = 1'b1;                       // Write back the victim first.
          if (pmem_resp) begin
            dirty_load = 1'b1;                     // Victim is clean once written.
            dirty_in   = 1'b0;
          end
        end
      end

      read_mem: begin
        pmem_read = 1'b1;
        if (pmem_resp) begin
          tag_load   = 1'b1;                       // Fill the victim way.
          valid_load = 1'b1;
          dirty_load = 1'b1;
          dirty_in   = 1'b0;
          data_sel   = data_sel_mem;
        end
      end

      default: ;
    endcase
  end

  // --------------------
  // Next state
  // --------------------
  always_comb begin : next_state_logic
    next_state = state;

    case (state)
      check_hit: begin
        if (req && !hit) begin
          if (dirty_out) begin
            if (pmem_resp) begin
              next_state = read_mem;               // Write-back done.
            end
          end else begin
            next_state = read_mem;                 // Clean miss, fetch right away.
          end
        end
      end

      read_mem: begin
        if (pmem_resp) begin
          next_state = check_hit;                  // Request hits on return.
        end
      end

      default: next_state = check_hit;
    endcase
  end

  always_ff @(posedge clk) begin : state_reg
    if (!rst_n) begin
      state <= check_hit;
    end else begin
      state <= next_state;
    end
  end

endmodule : cache_control

/* logic/cache_datapath.sv */
`timescale 1ns/1ps

module cache_datapath (
  input  logic                        clk,
  input  logic                        rst_n,

  // CPU side.
  input  cache_geom_pkg::addr_t       mem_address,
  input  cache_geom_pkg::data_t       mem_wdata,
  output cache_geom_pkg::data_t       mem_rdata,

  // Memory side.
  input  cache_geom_pkg::data_t       pmem_rdata,
  output cache_geom_pkg::addr_t       pmem_address,
  output cache_geom_pkg::data_t       pmem_wdata,

  // From the controller.
  input  logic                        tag_load,
  input  logic                        valid_load,
  input  logic                        dirty_load,
  input  logic                        dirty_in,
  input  cache_geom_pkg::data_sel_t   data_sel,
  input  logic                        lru_load [cache_geom_pkg::num_ways],
  input  cache_geom_pkg::way_t        lru_in [cache_geom_pkg::num_ways],

  // To the controller.
  output logic                        dirty_out,
  output logic                        hit,
  output cache_geom_pkg::way_t        way_idx,
  output logic                        valid_out [cache_geom_pkg::num_ways],
  output cache_geom_pkg::way_t        lru_out [cache_geom_pkg::num_ways]
);

  import cache_geom_pkg::*;

  // --------------------
  // Storage
  // --------------------
  tag_t  tag_q   [num_sets][num_ways];
  data_t data_q  [num_sets][num_ways];
  logic  valid_q [num_sets][num_ways];
  logic  dirty_q [num_sets][num_ways];
  way_t  lru_q   [num_sets][num_ways];

  set_t  req_set;
  tag_t  req_tag;
  way_t  hit_way;
  way_t  victim_way;
  logic  write_back;                                // Victim must go out first.

  assign req_set = mem_address[set_bits-1:0];
  assign req_tag = mem_address[set_bits +: tag_bits];

  // --------------------
  // Lookup
  // --------------------
  always_comb begin : tag_compare
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (valid_q[req_set][w] && (tag_q[req_set][w] == req_tag)) begin
        hit     = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  always_comb begin : victim_select
    victim_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (lru_q[req_set][w] > lru_q[req_set][victim_way]) begin
        victim_way = way_t'(w);                    // Oldest age.
      end
    end
    // Scan downward so the lowest free way wins.
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (!valid_q[req_set][w]) begin
        victim_way = way_t'(w);
      end
    end
  end

  assign way_idx   = hit ? hit_way : victim_way;
  assign dirty_out = dirty_q[req_set][way_idx];
  assign mem_rdata = data_q[req_set][way_idx];

  always_comb begin : set_view
    for (int w = 0; w < num_ways; w++) begin
      valid_out[w] = valid_q[req_set][w];
      lru_out[w]   = lru_q[req_set][w];
    end
  end

  // Write-back goes to the victim's own line, everything else to the request.
  assign write_back   = !hit && dirty_out;
  assign pmem_address = write_back ? {tag_q[req_set][way_idx], req_set} : mem_address;
  assign pmem_wdata   = data_q[req_set][way_idx];

  // --------------------
  // Control state arrays
  // --------------------
  always_ff @(posedge clk) begin : status_arrays
    if (!rst_n) begin
      for (int s = 0; s < num_sets; s++) begin
        for (int w = 0; w < num_ways; w++) begin
          valid_q[s][w] <= 1'b0;
          dirty_q[s][w] <= 1'b0;
          lru_q[s][w]   <= way_t'(num_ways - 1);     // All ways start oldest.
        end
      end
    end else begin
      if (valid_load) begin
        valid_q[req_set][way_idx] <= 1'b1;
      end
      if (dirty_load) begin
        dirty_q[req_set][way_idx] <= dirty_in;
      end
      for (int w = 0; w < num_ways; w++) begin
        if (lru_load[w]) begin
          lru_q[req_set][w] <= lru_in[w];
        end
      end
    end
  end

  // --------------------
  // Tag and data arrays
  // --------------------
  always_ff @(posedge clk) begin : line_arrays
    if (tag_load) begin
      tag_q[req_set][way_idx] <= req_tag;
    end
    case (data_sel)
      data_sel_mem: data_q[req_set][way_idx] <= pmem_rdata;
      data_sel_cpu: data_q[req_set][way_idx] <= mem_wdata;
      default: ;                                   // No write.
    endcase
  end

endmodule : cache_datapath

/* logic/pmem_arbiter.sv */
`timescale 1ns/1ps

module pmem_arbiter (
  input  logic                  clk,
  input  logic                  rst_n,

  // One entry per cache.
  input  logic                  req_read [pmem_pkg::num_requesters],
  input  logic                  req_write [pmem_pkg::num_requesters],
  input  cache_geom_pkg::addr_t req_address [pmem_pkg::num_requesters],
  input  cache_geom_pkg::data_t req_wdata [pmem_pkg::num_requesters],
  output logic                  req_resp [pmem_pkg::num_requesters],
  output cache_geom_pkg::data_t req_rdata [pmem_pkg::num_requesters],

  // Shared memory port.
  output logic                  pmem_read,
  output logic                  pmem_write,
  output cache_geom_pkg::addr_t pmem_address,
  output cache_geom_pkg::data_t pmem_wdata,
  input  logic                  pmem_resp,
  input  cache_geom_pkg::data_t pmem_rdata
);

  import pmem_pkg::*;

  logic    busy_q;                                 // Grant held until response.
  req_id_t owner_q;
  req_id_t prio_q;                                 // Round-robin pointer.
  req_id_t pick;
  req_id_t cur;
  logic    any_req;
  logic    active;
  logic    want [num_requesters];

  always_comb begin : request_select
    any_req = 1'b0;
    for (int i = 0; i < num_requesters; i++) begin
      want[i] = req_read[i] | req_write[i];
      any_req = any_req | want[i];
    end
    pick = want[prio_q] ? prio_q : prio_q + req_id_t'(1);
  end

  // A new grant takes effect in the cycle it is made.
  assign cur    = busy_q ? owner_q : pick;
  assign active = busy_q | any_req;

  assign pmem_read    = active & req_read[cur];
  assign pmem_write   = active & req_write[cur];
  assign pmem_address = req_address[cur];
  assign pmem_wdata   = req_wdata[cur];

  always_comb begin : response_route
    for (int i = 0; i < num_requesters; i++) begin
      req_resp[i]  = pmem_resp && active && (cur == req_id_t'(i));
      req_rdata[i] = pmem_rdata;
    end
  end

  always_ff @(posedge clk) begin : grant_reg
    if (!rst_n) begin
      busy_q  <= 1'b0;
      owner_q <= '0;
      prio_q  <= '0;
    end else if (active && pmem_resp) begin
      busy_q <= 1'b0;
      prio_q <= cur + req_id_t'(1);                // Other cache goes first next.
    end else if (!busy_q && any_req) begin
      busy_q  <= 1'b1;
      owner_q <= pick;
    end
  end

endmodule : pmem_arbiter

/* logic/dual_cache_top.sv */
`timescale 1ns/1ps

module dual_cache_top (
  input  logic                  clk,
  input  logic                  rst_n,

  // Instruction fetch.
  input  logic                  i_mem_read,
  input  cache_geom_pkg::addr_t i_mem_address,
  output logic                  i_mem_resp,
  output cache_geom_pkg::data_t i_mem_rdata,

  // Data access.
  input  logic                  d_mem_read,
  input  logic                  d_mem_write,
  input  cache_geom_pkg::addr_t d_mem_address,
  input  cache_geom_pkg::data_t d_mem_wdata,
  output logic                  d_mem_resp,
  output cache_geom_pkg::data_t d_mem_rdata,

  // Physical memory.
  output logic                  pmem_read,
  output logic                  pmem_write,
  output cache_geom_pkg::addr_t pmem_address,
  output cache_geom_pkg::data_t pmem_wdata,
  input  logic                  pmem_resp,
  input  cache_geom_pkg::data_t pmem_rdata
);

  import cache_geom_pkg::*;
  import pmem_pkg::*;

  // --------------------
  // Arbiter side
  // --------------------
  logic  req_read [num_requesters];
  logic  req_write [num_requesters];
  addr_t req_address [num_requesters];
  data_t req_wdata [num_requesters];
  logic  req_resp [num_requesters];
  data_t req_rdata [num_requesters];

  // --------------------
  // Controller to datapath
  // --------------------
  logic      i_tag_load, d_tag_load;
  logic      i_valid_load, d_valid_load;
  logic      i_dirty_load, d_dirty_load;
  logic      i_dirty_in, d_dirty_in;
  logic      i_dirty_out, d_dirty_out;
  logic      i_hit, d_hit;
  data_sel_t i_data_sel, d_data_sel;
  way_t      i_way_idx, d_way_idx;
  logic      i_lru_load [num_ways];
  logic      d_lru_load [num_ways];
  way_t      i_lru_in [num_ways];
  way_t      d_lru_in [num_ways];
  logic      i_valid_out [num_ways];
  logic      d_valid_out [num_ways];
  way_t      i_lru_out [num_ways];
  way_t      d_lru_out [num_ways];

  cache_control u_icache_control (
    .clk, .rst_n,
    .mem_read   (i_mem_read),
    .mem_write  (1'b0),                           // Fetch never stores.
    .mem_resp   (i_mem_resp),
    .pmem_resp  (req_resp[req_icache]),
    .pmem_read  (req_read[req_icache]),
    .pmem_write (req_write[req_icache]),
    .tag_load   (i_tag_load),   .valid_load (i_valid_load),
    .dirty_load (i_dirty_load), .dirty_in   (i_dirty_in),
    .dirty_out  (i_dirty_out),  .hit        (i_hit),
    .data_sel   (i_data_sel),   .lru_out    (i_lru_out),
    .way_idx    (i_way_idx),    .valid_out  (i_valid_out),
    .lru_load   (i_lru_load),   .lru_in     (i_lru_in)
  );

  cache_datapath u_icache_datapath (
    .clk, .rst_n,
    .mem_address  (i_mem_address),
    .mem_wdata    ('0),
    .mem_rdata    (i_mem_rdata),
    .pmem_rdata   (req_rdata[req_icache]),
    .pmem_address (req_address[req_icache]),
    .pmem_wdata   (req_wdata[req_icache]),
    .tag_load   (i_tag_load),   .valid_load (i_valid_load),
    .dirty_load (i_dirty_load), .dirty_in   (i_dirty_in),
    .data_sel   (i_data_sel),   .lru_load   (i_lru_load),
    .lru_in     (i_lru_in),     .dirty_out  (i_dirty_out),
    .hit        (i_hit),        .way_idx    (i_way_idx),
    .valid_out  (i_valid_out),  .lru_out    (i_lru_out)
  );

  cache_control u_dcache_control (
    .clk, .rst_n,
    .mem_read   (d_mem_read),
    .mem_write  (d_mem_write),
    .mem_resp   (d_mem_resp),
    .pmem_resp  (req_resp[req_dcache]),
    .pmem_read  (req_read[req_dcache]),
    .pmem_write (req_write[req_dcache]),
    .tag_load   (d_tag_load),   .valid_load (d_valid_load),
    .dirty_load (d_dirty_load), .dirty_in   (d_dirty_in),
    .dirty_out  (d_dirty_out),  .hit        (d_hit),
    .data_sel   (d_data_sel),   .lru_out    (d_lru_out),
    .way_idx    (d_way_idx),    .valid_out  (d_valid_out),
    .lru_load   (d_lru_load),   .lru_in     (d_lru_in)
  );

  cache_datapath u_dcache_datapath (
    .clk, .rst_n,
    .mem_address  (d_mem_address),
    .mem_wdata    (d_mem_wdata),
    .mem_rdata    (d_mem_rdata),
    .pmem_rdata   (req_rdata[req_dcache]),
    .pmem_address (req_address[req_dcache]),
    .pmem_wdata   (req_wdata[req_dcache]),
    .tag_load   (d_tag_load),   .valid_load (d_valid_load),
    .dirty_load (d_dirty_load), .dirty_in   (d_dirty_in),
    .data_sel   (d_data_sel),   .lru_load   (d_lru_load),
    .lru_in     (d_lru_in),     .dirty_out  (d_dirty_out),
    .hit        (d_hit),        .way_idx    (d_way_idx),
    .valid_out  (d_valid_out),  .lru_out    (d_lru_out)
  );

  pmem_arbiter u_pmem_arbiter (
    .clk, .rst_n,
    .req_read, .req_write, .req_address, .req_wdata, .req_resp, .req_rdata,
    .pmem_read, .pmem_write, .pmem_address, .pmem_wdata, .pmem_resp, .pmem_rdata
  );

endmodule : dual_cache_top

/* verification/dual_cache_tb.sv */
`timescale 1ns/1ps

module dual_cache_tb;

  import cache_geom_pkg::*;

  localparam int mem_words   = 1 << addr_bits;
  localparam int mem_latency = 3;                    // Cycles from strobe to response.
  // About 150 cycles of traffic over the five tests plus reset, with margin.
  localparam int max_cycles  = 400;

  logic  clk;
  logic  rst_n;
  logic  i_mem_read;
  addr_t i_mem_address;
  logic  i_mem_resp;
  data_t i_mem_rdata;
  logic  d_mem_read;
  logic  d_mem_write;
  addr_t d_mem_address;
  data_t d_mem_wdata;
  logic  d_mem_resp;
  data_t d_mem_rdata;
  logic  pmem_read;
  logic  pmem_write;
  addr_t pmem_address;
  data_t pmem_wdata;
  logic  pmem_resp;
  data_t pmem_rdata;

  data_t mem_model  [mem_words];                     // Backing store behind the port.
  data_t expect_mem [mem_words];                     // Word the CPU should see.

  int    cycle_count   = 0;
  int    err_count     = 0;
  int    check_count   = 0;
  int    strobe_cycles = 0;
  int    read_count    = 0;
  int    write_count   = 0;
  int    wait_cnt      = 0;
  logic  resp_next;
  data_t rdata_next;
  addr_t txn_addr;
  logic  txn_write;
  addr_t last_wb_addr;
  data_t last_wb_data;

  dual_cache_top u_dual_cache_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_mem_read    (i_mem_read),
    .i_mem_address (i_mem_address),
    .i_mem_resp    (i_mem_resp),
    .i_mem_rdata   (i_mem_rdata),
    .d_mem_read    (d_mem_read),
    .d_mem_write   (d_mem_write),
    .d_mem_address (d_mem_address),
    .d_mem_wdata   (d_mem_wdata),
    .d_mem_resp    (d_mem_resp),
    .d_mem_rdata   (d_mem_rdata),
    .pmem_read     (pmem_read),
    .pmem_write    (pmem_write),
    .pmem_address  (pmem_address),
    .pmem_wdata    (pmem_wdata),
    .pmem_resp     (pmem_resp),
    .pmem_rdata    (pmem_rdata)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin : watchdog
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("Timeout after %0d cycles, a cache request never completed", cycle_count);
      $display("** FAIL **");
      $finish;
    end
  end

  // --------------------
  // Memory model
  // --------------------
  always @(posedge clk) begin : pmem_model
    if (rst_n && (pmem_read || pmem_write)) begin
      strobe_cycles++;
    end
    if (!rst_n) begin
      wait_cnt  = 0;
      resp_next = 1'b0;
    end else if (pmem_resp) begin
      if (pmem_write) begin                          // Write lands when the response is taken.
        mem_model[pmem_address] = pmem_wdata;
        last_wb_addr = pmem_address;
        last_wb_data = pmem_wdata;
        write_count++;
      end else begin
        read_count++;
      end
      wait_cnt  = 0;
      resp_next = 1'b0;
    end else if (pmem_read || pmem_write) begin
      if (pmem_read && pmem_write) begin
        $display("Read and write strobes both high on the memory port at %0t ns", $time);
        err_count++;
      end
      if (wait_cnt == 0) begin
        txn_addr  = pmem_address;                    // First cycle of a transaction.
        txn_write = pmem_write;
      end else if ((pmem_address !== txn_addr) || (pmem_write !== txn_write)) begin
        $display("Memory request switched before its response at %0t ns", $time);
        err_count++;
      end
      wait_cnt++;
      if (wait_cnt == mem_latency) begin
        resp_next  = 1'b1;
        rdata_next = mem_model[pmem_address];
      end
    end
  end

  always @(negedge clk) begin : pmem_drive
    pmem_resp  = resp_next;
    pmem_rdata = rdata_next;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // --------------------
  // Helpers
  // --------------------
  task automatic check_value(input string name, input data_t got, input data_t exp);
    check_count++;
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s finished with %0d errors", name, err_count - errs_before);
  endtask

  // Holds the request until the cache answers, then drops it.
  task automatic cpu_access(input logic dside, input logic write, input addr_t addr,
                            input data_t wdata, output data_t rdata);
    @(negedge clk);
    if (dside) begin
      d_mem_read    = !write;
      d_mem_write   = write;
      d_mem_address = addr;
      d_mem_wdata   = wdata;
    end else begin
      i_mem_read    = 1'b1;
      i_mem_address = addr;
    end
    forever begin
      @(posedge clk);
      if (dside ? d_mem_resp : i_mem_resp) break;
    end
    rdata = dside ? d_mem_rdata : i_mem_rdata;
    @(negedge clk);
    if (dside) begin
      d_mem_read  = 1'b0;
      d_mem_write = 1'b0;
    end else begin
      i_mem_read = 1'b0;
    end
  endtask

  task automatic read_and_check(input logic dside, input addr_t addr);
    data_t rdata;
    string name;
    cpu_access(dside, 1'b0, addr, '0, rdata);
    if (dside) name = "d_mem_rdata";
    else name = "i_mem_rdata";
    check_value(name, rdata, expect_mem[addr]);
  endtask

  task automatic write_word(input addr_t addr, input data_t data);
    data_t ignored;
    cpu_access(1'b1, 1'b1, addr, data, ignored);
    expect_mem[addr] = data;
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic read_miss_then_hit();
    int errs;
    int reads;
    int strobes;
    errs  = err_count;
    reads = read_count;
    read_and_check(1'b0, 16'h0010);                  // Miss on each cache.
    read_and_check(1'b1, 16'h0021);
    check_value("pmem reads", read_count, reads + 2);
    strobes = strobe_cycles;
    read_and_check(1'b0, 16'h0010);                  // Both hit now.
    read_and_check(1'b1, 16'h0021);
    check_value("pmem strobe cycles", strobe_cycles, strobes);
    report_test("read_miss_then_hit", errs);
  endtask

  task automatic write_then_read();
    int    errs;
    data_t old_word;
    errs     = err_count;
    old_word = mem_model[16'h0032];
    write_word(16'h0032, 32'hcafe_0032);
    read_and_check(1'b1, 16'h0032);
    check_value("memory word 0x0032", mem_model[16'h0032], old_word);
    report_test("write_then_read", errs);
  endtask

  task automatic lru_eviction();
    int errs;
    int reads;
    int strobes;
    errs = err_count;
    read_and_check(1'b1, 16'h0003);                  // Set 3, tags 0 to 3.
    read_and_check(1'b1, 16'h000b);
    read_and_check(1'b1, 16'h0013);
    read_and_check(1'b1, 16'h001b);
    read_and_check(1'b1, 16'h0003);                  // Touch, so 0x000b is oldest.
    reads = read_count;
    read_and_check(1'b1, 16'h0023);
    check_value("pmem reads", read_count, reads + 1);
    strobes = strobe_cycles;
    read_and_check(1'b1, 16'h0003);
    check_value("pmem strobe cycles", strobe_cycles, strobes);
    reads = read_count;
    read_and_check(1'b1, 16'h000b);                  // Evicted, so it refetches.
    check_value("pmem reads", read_count, reads + 1);
    report_test("lru_eviction", errs);
  endtask

  task automatic dirty_eviction();
    int errs;
    int writes;
    errs = err_count;
    write_word(16'h0004, 32'h5eed_0004);
    read_and_check(1'b1, 16'h000c);                  // Fill the rest of set 4.
    read_and_check(1'b1, 16'h0014);
    read_and_check(1'b1, 16'h001c);
    writes = write_count;
    read_and_check(1'b1, 16'h0024);                  // Pushes out the dirty word.
    check_value("pmem writes", write_count, writes + 1);
    check_value("pmem_address", data_t'(last_wb_addr), 32'h0000_0004);
    check_value("pmem_wdata", last_wb_data, 32'h5eed_0004);
    read_and_check(1'b0, 16'h0004);
    report_test("dirty_eviction", errs);
  endtask

  task automatic concurrent_misses();
    int    errs;
    int    reads;
    data_t i_word;
    data_t d_word;
    errs  = err_count;
    reads = read_count;
    fork
      cpu_access(1'b0, 1'b0, 16'h0045, '0, i_word);
      cpu_access(1'b1, 1'b0, 16'h0056, '0, d_word);
    join
    check_value("i_mem_rdata", i_word, expect_mem[16'h0045]);
    check_value("d_mem_rdata", d_word, expect_mem[16'h0056]);
    check_value("pmem reads", read_count, reads + 2);
    report_test("concurrent_misses", errs);
  endtask

  initial begin : main
    logic [31:0] seed;
    i_mem_read    = 1'b0;
    i_mem_address = '0;
    d_mem_read    = 1'b0;
    d_mem_write   = 1'b0;
    d_mem_address = '0;
    d_mem_wdata   = '0;
    pmem_resp     = 1'b0;
    pmem_rdata    = '0;
    resp_next     = 1'b0;
    rdata_next    = '0;
    rst_n         = 1'b0;
    seed          = 32'd17581;
    for (int a = 0; a < mem_words; a++) begin
      seed          = lcg_next(seed);
      mem_model[a]  = seed;
      expect_mem[a] = seed;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    read_miss_then_hit();
    write_then_read();
    lru_eviction();
    dirty_eviction();
    concurrent_misses();

    $display("Summary: %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : dual_cache_tb

/* flist.f */
logic/cache_geom_pkg.sv
logic/pmem_pkg.sv
logic/cache_control.sv
logic/cache_datapath.sv
logic/pmem_arbiter.sv
logic/dual_cache_top.sv
verification/dual_cache_tb.sv

/* run.sh */
#!/bin/sh
# Build the dual cache testbench with Verilator, run it and scan the log.
log=sim.log

verilator --binary --timing -Wno-fatal --top-module dual_cache_tb \
    -o dual_cache_sim -f flist.f &&
  ./obj_dir/dual_cache_sim > "$log" 2>&1 ||
  { cat "$log" 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat "$log"
grep -qF '** FAIL **' "$log" && { echo "Simulation reported failure"; exit 1; }
grep -qF '** PASS **' "$log" || { echo "Simulation did not finish"; exit 1; }
exit 0
